// File: logic/commit_cfg.svh
`ifndef COMMIT_CFG_SVH
`define COMMIT_CFG_SVH

// widths
`define XLEN        32
`define AREG_W      5
`define CSR_NUM_W   14
`define HW_INT_NUM  8
`define ECODE_W     6

// csr numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030

// ------------------------------
// field positions
`define CRMD_PLV    1:0
`define CRMD_IE     2
`define CRMD_DA     3
`define PRMD_PPLV   1:0
`define PRMD_PIE    2
`define ECFG_LIE    9:0
`define ESTAT_IS    9:0
`define ESTAT_SIS   1:0
`define ESTAT_HIS   9:2
`define ESTAT_ECODE 21:16
`define EENTRY_VA   31:6

// ------------------------------
// exception codes
`define ECODE_INT   6'h00
`define ECODE_ADEF  6'h08
`define ECODE_ALE   6'h09
`define ECODE_SYS   6'h0b
`define ECODE_BRK   6'h0c
`define ECODE_INE   6'h0d
`define ECODE_IPE   6'h0e

`endif

// File: logic/commit_pkg.sv
`include "commit_cfg.svh"

package commit_pkg;

    // one data word
    typedef logic [`XLEN-1:0] word_t;

    // fault already attached to an instruction in the reorder buffer
    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ADEF,
        EXC_ALE,
        EXC_SYS,
        EXC_BRK,
        EXC_INE
    } exc_class_e;

    // privileged operation carried by slot 0
    typedef enum logic [2:0] {
        CSR_NONE,
        // read only, old value to rd
        CSR_RD,
        // full write, old value to rd
        CSR_WR,
        // masked write, old value to rd
        CSR_XCHG,
        // exception return
        CSR_ERTN
    } csr_op_e;

endpackage

// File: logic/commit_if.sv
`include "commit_cfg.svh"

interface commit_if
    import commit_pkg::*;
();

    // retire decision and slot 0 csr request
    logic                  take0;
    logic                  take1;
    logic                  exc_take;
    logic [`ECODE_W-1:0]   exc_code;
    csr_op_e               csr_op;
    logic [`CSR_NUM_W-1:0] csr_num;
    word_t                 csr_wdata;
    word_t                 csr_mask;
    word_t                 pc0;

    // csr state seen by the other two blocks
    word_t                 csr_rdata;
    logic                  int_pending;
    logic [1:0]            cur_plv;
    word_t                 eentry;
    word_t                 era;

    modport issue (
        output take0, take1, exc_take, exc_code,
        output csr_op, csr_num, csr_wdata, csr_mask, pc0,
        input  int_pending, cur_plv
    );

    modport csr (
        input  exc_take, exc_code, csr_op, csr_num, csr_wdata, csr_mask, pc0,
        output csr_rdata, int_pending, cur_plv, eentry, era
    );

    modport wb (
        input  take0, take1, exc_take, csr_op, csr_rdata, eentry, era
    );

endinterface

// File: logic/commit_issue.sv
`include "commit_cfg.svh"

module commit_issue
    import commit_pkg::*;
(
    input  logic [1:0]                  rob_valid_i,
    input  logic [1:0]                  rob_single_i,
    input  exc_class_e [1:0]            rob_exc_i,
    input  csr_op_e [1:0]               rob_csr_op_i,
    input  logic [1:0][`CSR_NUM_W-1:0]  rob_csr_num_i,
    input  word_t [1:0]                 rob_wdata_i,
    input  word_t [1:0]                 rob_mask_i,
    input  word_t [1:0]                 rob_pc_i,
    output logic [1:0]                  commit_req_o,
    commit_if.issue                     ci
);

    logic [`ECODE_W-1:0] class_code;
    logic                has_class0;
    logic                priv_fault;
    logic                pair_ok;

    // ------------------------------
    // exception arbitration, slot 0 only
    always_comb begin
        case (rob_exc_i[0])
            EXC_ADEF: class_code = `ECODE_ADEF;
            EXC_ALE:  class_code = `ECODE_ALE;
            EXC_SYS:  class_code = `ECODE_SYS;
            EXC_BRK:  class_code = `ECODE_BRK;
            EXC_INE:  class_code = `ECODE_INE;
            default:  class_code = `ECODE_INT;
        endcase
    end

    assign has_class0 = (rob_exc_i[0] != EXC_NONE);
    // any privileged op from user level
    assign priv_fault = (rob_csr_op_i[0] != CSR_NONE) && (ci.cur_plv == 2'd3);

    always_comb begin
        ci.exc_take = 1'b0;
        ci.exc_code = `ECODE_INT;
        if (rob_valid_i[0]) begin
            if (ci.int_pending) begin
                ci.exc_take = 1'b1;
            end else if (has_class0) begin
                ci.exc_take = 1'b1;
                ci.exc_code = class_code;
            end else if (priv_fault) begin
                ci.exc_take = 1'b1;
                ci.exc_code = `ECODE_IPE;
            end
        end
    end

    // ------------------------------
    // dual retire only for two plain instructions
    assign pair_ok = (&rob_valid_i) && !(|rob_single_i)
                  && (rob_exc_i[0] == EXC_NONE) && (rob_exc_i[1] == EXC_NONE)
                  && (rob_csr_op_i[0] == CSR_NONE) && (rob_csr_op_i[1] == CSR_NONE);

    assign ci.take0 = rob_valid_i[0];
    assign ci.take1 = pair_ok && !ci.exc_take;
    assign commit_req_o = {ci.take1, ci.take0};

    // csr request dropped when the instruction traps
    assign ci.csr_op    = (rob_valid_i[0] && !ci.exc_take) ? rob_csr_op_i[0] : CSR_NONE;
    assign ci.csr_num   = rob_csr_num_i[0];
    assign ci.csr_wdata = rob_wdata_i[0];
    assign ci.csr_mask  = rob_mask_i[0];
    assign ci.pc0       = rob_pc_i[0];

endmodule

// File: logic/csr_unit.sv
`include "commit_cfg.svh"

module csr_unit
    import commit_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`HW_INT_NUM-1:0] hw_int_i,
    commit_if.csr                  ci
);

    word_t crmd;
    word_t prmd;
    word_t ecfg;
    word_t estat;
    word_t era;
    word_t eentry;
    word_t save0;

    word_t rdata;
    word_t wr_val;
    logic  csr_wr;

    // ------------------------------
    // read port, old value of the addressed csr
    always_comb begin
        case (ci.csr_num)
            `CSR_CRMD:   rdata = crmd;
            `CSR_PRMD:   rdata = prmd;
            `CSR_ECFG:   rdata = ecfg;
            `CSR_ESTAT:  rdata = estat;
            `CSR_ERA:    rdata = era;
            `CSR_EENTRY: rdata = eentry;
            `CSR_SAVE0:  rdata = save0;
            default:     rdata = '0;
        endcase
    end

    assign csr_wr = (ci.csr_op == CSR_WR) || (ci.csr_op == CSR_XCHG);

    // exchange keeps old bits where the mask is clear
    assign wr_val = (ci.csr_op == CSR_XCHG) ?
                    ((rdata & ~ci.csr_mask) | (ci.csr_wdata & ci.csr_mask)) :
                    ci.csr_wdata;

    // ------------------------------
    // state update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd   <= '0;
            crmd[`CRMD_DA] <= 1'b1;
            prmd   <= '0;
            ecfg   <= '0;
            estat  <= '0;
            era    <= '0;
            eentry <= '0;
            save0  <= '0;
        end else begin
            // hardware lines sampled every cycle
            estat[`ESTAT_HIS] <= hw_int_i;

            if (ci.exc_take) begin
                era                 <= ci.pc0;
                prmd[`PRMD_PPLV]    <= crmd[`CRMD_PLV];
                prmd[`PRMD_PIE]     <= crmd[`CRMD_IE];
                crmd[`CRMD_PLV]     <= 2'd0;
                crmd[`CRMD_IE]      <= 1'b0;
                estat[`ESTAT_ECODE] <= ci.exc_code;
            end else if (ci.csr_op == CSR_ERTN) begin
                crmd[`CRMD_PLV] <= prmd[`PRMD_PPLV];
                crmd[`CRMD_IE]  <= prmd[`PRMD_PIE];
            end else if (csr_wr) begin
                case (ci.csr_num)
                    `CSR_CRMD:   crmd <= wr_val;
                    `CSR_PRMD:   prmd <= wr_val;
                    `CSR_ECFG:   ecfg <= wr_val;
                    // only the software interrupt bits are writable
                    `CSR_ESTAT:  estat[`ESTAT_SIS] <= wr_val[`ESTAT_SIS];
                    `CSR_ERA:    era <= wr_val;
                    `CSR_EENTRY: eentry <= {wr_val[`EENTRY_VA], 6'b0};
                    `CSR_SAVE0:  save0 <= wr_val;
                    default:     ;
                endcase
            end
        end
    end

    // ------------------------------
    // outputs
    assign ci.csr_rdata   = rdata;
    assign ci.int_pending = crmd[`CRMD_IE] && (|(estat[`ESTAT_IS] & ecfg[`ECFG_LIE]));
    assign ci.cur_plv     = crmd[`CRMD_PLV];
    assign ci.eentry      = eentry;
    assign ci.era         = era;

endmodule

// File: logic/commit_writeback.sv
`include "commit_cfg.svh"

module commit_writeback
    import commit_pkg::*;
(
    input  logic [1:0]              rob_wen_i,
    input  logic [1:0][`AREG_W-1:0] rob_areg_i,
    input  word_t [1:0]             rob_wdata_i,
    input  word_t [1:0]             rob_pc_i,
    commit_if.wb                    ci,
    output logic [1:0]              arf_we_o,
    output logic [1:0][`AREG_W-1:0] arf_areg_o,
    output word_t [1:0]             arf_data_o,
    output logic                    flush_o,
    output word_t                   redirect_pc_o
);

    logic csr_to_rd;

    // ops that return the old csr value
    assign csr_to_rd = (ci.csr_op == CSR_RD) || (ci.csr_op == CSR_WR)
                    || (ci.csr_op == CSR_XCHG);

    // ------------------------------
    // register file ports
    always_comb begin
        arf_we_o[0]   = ci.take0 && rob_wen_i[0] && !ci.exc_take;
        arf_we_o[1]   = ci.take1 && rob_wen_i[1] && !ci.exc_take;
        arf_areg_o    = rob_areg_i;
        arf_data_o[0] = csr_to_rd ? ci.csr_rdata : rob_wdata_i[0];
        arf_data_o[1] = rob_wdata_i[1];
    end

    // ------------------------------
    // flush and redirect
    always_comb begin
        flush_o       = 1'b0;
        redirect_pc_o = '0;
        if (ci.exc_take) begin
            flush_o       = 1'b1;
            redirect_pc_o = ci.eentry;
        end else begin
            case (ci.csr_op)
                CSR_ERTN: begin
                    flush_o       = 1'b1;
                    redirect_pc_o = ci.era;
                end
                // csr state changed, refetch after the writer
                CSR_WR, CSR_XCHG: begin
                    flush_o       = 1'b1;
                    redirect_pc_o = rob_pc_i[0] + 32'd4;
                end
                default: begin
                    flush_o = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: logic/commit_stage.sv
`include "commit_cfg.svh"

module commit_stage
    import commit_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,

    // reorder buffer head, slot 0 is the older one
    input  logic [1:0]                  rob_valid_i,
    input  word_t [1:0]                 rob_pc_i,
    input  logic [1:0]                  rob_wen_i,
    input  logic [1:0][`AREG_W-1:0]     rob_areg_i,
    input  word_t [1:0]                 rob_wdata_i,
    input  logic [1:0]                  rob_single_i,
    input  exc_class_e [1:0]            rob_exc_i,
    input  csr_op_e [1:0]               rob_csr_op_i,
    input  logic [1:0][`CSR_NUM_W-1:0]  rob_csr_num_i,
    input  word_t [1:0]                 rob_mask_i,

    input  logic [`HW_INT_NUM-1:0]      hw_int_i,

    output logic [1:0]                  commit_req_o,
    output logic [1:0]                  arf_we_o,
    output logic [1:0][`AREG_W-1:0]     arf_areg_o,
    output word_t [1:0]                 arf_data_o,
    output logic                        flush_o,
    output word_t                       redirect_pc_o
);

    commit_if cif ();

    commit_issue u_issue (
        .rob_valid_i   (rob_valid_i),
        .rob_single_i  (rob_single_i),
        .rob_exc_i     (rob_exc_i),
        .rob_csr_op_i  (rob_csr_op_i),
        .rob_csr_num_i (rob_csr_num_i),
        .rob_wdata_i   (rob_wdata_i),
        .rob_mask_i    (rob_mask_i),
        .rob_pc_i      (rob_pc_i),
        .commit_req_o  (commit_req_o),
        .ci            (cif.issue)
    );

    csr_unit u_csr (
        .clk      (clk),
        .rst_n    (rst_n),
        .hw_int_i (hw_int_i),
        .ci       (cif.csr)
    );

    commit_writeback u_wb (
        .rob_wen_i     (rob_wen_i),
        .rob_areg_i    (rob_areg_i),
        .rob_wdata_i   (rob_wdata_i),
        .rob_pc_i      (rob_pc_i),
        .ci            (cif.wb),
        .arf_we_o      (arf_we_o),
        .arf_areg_o    (arf_areg_o),
        .arf_data_o    (arf_data_o),
        .flush_o       (flush_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

// File: tb/tb_commit_stage.sv
`include "commit_cfg.svh"

module tb_commit_stage
    import commit_pkg::*;
();

    // one reorder buffer entry
    typedef struct packed {
        word_t                 pc;
        logic                  wen;
        logic [`AREG_W-1:0]    areg;
        word_t                 wdata;
        logic                  single;
        exc_class_e            exc;
        csr_op_e               op;
        logic [`CSR_NUM_W-1:0] num;
        word_t                 mask;
    } instr_t;

    logic                       clk;
    logic                       rst_n;
    logic [1:0]                 rob_valid_i;
    word_t [1:0]                rob_pc_i;
    logic [1:0]                 rob_wen_i;
    logic [1:0][`AREG_W-1:0]    rob_areg_i;
    word_t [1:0]                rob_wdata_i;
    logic [1:0]                 rob_single_i;
    exc_class_e [1:0]           rob_exc_i;
    csr_op_e [1:0]              rob_csr_op_i;
    logic [1:0][`CSR_NUM_W-1:0] rob_csr_num_i;
    word_t [1:0]                rob_mask_i;
    logic [`HW_INT_NUM-1:0]     hw_int_i;
    logic [1:0]                 commit_req_o;
    logic [1:0]                 arf_we_o;
    logic [1:0][`AREG_W-1:0]    arf_areg_o;
    word_t [1:0]                arf_data_o;
    logic                       flush_o;
    word_t                      redirect_pc_o;

    // reference csr state
    word_t m_crmd;
    word_t m_prmd;
    word_t m_ecfg;
    word_t m_estat;
    word_t m_era;
    word_t m_eentry;
    word_t m_save0;

    // predicted responses for the current head
    logic                exp_pend;
    logic                exp_exc;
    logic [`ECODE_W-1:0] exp_code;
    csr_op_e             exp_op;
    word_t               exp_old;
    word_t               exp_new;
    logic [1:0]          exp_req;
    logic [1:0]          exp_we;
    word_t               exp_data0;
    logic                exp_flush;
    word_t               exp_redirect;

    instr_t      pending[$];
    word_t       next_pc = 32'h1c00_0000;
    logic [31:0] lfsr = 32'h1d23;
    int          exc_seen = 0;

    commit_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // helpers
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic value_error(input string name, input word_t got, input word_t want);
        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, want);
        stop_run("DUT output does not match the reference model");
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic word_t rand_bits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic instr_t make_instr(input csr_op_e op, input logic [`CSR_NUM_W-1:0] num,
                                          input word_t wdata, input word_t mask);
        instr_t it;
        it.pc     = next_pc;
        it.wen    = 1'b1;
        it.areg   = `AREG_W'(rand_bits(`AREG_W));
        it.wdata  = wdata;
        it.single = 1'b0;
        it.exc    = EXC_NONE;
        it.op     = op;
        it.num    = num;
        it.mask   = mask;
        next_pc   = next_pc + 32'd4;
        return it;
    endfunction

    function automatic instr_t plain_instr();
        return make_instr(CSR_NONE, '0, rand_bits(32), '0);
    endfunction

    function automatic logic [`ECODE_W-1:0] class_code(input exc_class_e c);
        case (c)
            EXC_ADEF: return `ECODE_ADEF;
            EXC_ALE:  return `ECODE_ALE;
            EXC_SYS:  return `ECODE_SYS;
            EXC_BRK:  return `ECODE_BRK;
            EXC_INE:  return `ECODE_INE;
            default:  return `ECODE_INT;
        endcase
    endfunction

    // drive the two oldest queued entries
    task automatic present_head();
        instr_t s;
        for (int k = 0; k < 2; k++) begin
            s = (pending.size() > k) ? pending[k] : '0;
            rob_valid_i[k]   <= (pending.size() > k);
            rob_pc_i[k]      <= s.pc;
            rob_wen_i[k]     <= s.wen;
            rob_areg_i[k]    <= s.areg;
            rob_wdata_i[k]   <= s.wdata;
            rob_single_i[k]  <= s.single;
            rob_exc_i[k]     <= s.exc;
            rob_csr_op_i[k]  <= s.op;
            rob_csr_num_i[k] <= s.num;
            rob_mask_i[k]    <= s.mask;
        end
    endtask

    // retire everything queued while unrequested entries stay at the head
    task automatic drain_queue();
        int         cycles;
        logic [1:0] done;
        cycles = 0;
        while (pending.size() > 0) begin
            if (cycles == 20) begin
                stop_run("reorder buffer head was not retired within 20 cycles");
            end
            @(posedge clk);
            present_head();
            @(negedge clk);
            done = rob_valid_i & commit_req_o;
            if (done[0]) void'(pending.pop_front());
            if (done[1]) void'(pending.pop_front());
            cycles++;
        end
        @(posedge clk);
        rob_valid_i <= 2'b00;
    endtask

    // ------------------------------
    // reference model
    always_comb begin
        exp_pend = m_crmd[2] && ((m_estat[9:0] & m_ecfg[9:0]) != 10'd0);
        exp_exc  = rob_valid_i[0] && (exp_pend || rob_exc_i[0] != EXC_NONE
                   || (rob_csr_op_i[0] != CSR_NONE && m_crmd[1:0] == 2'd3));
        if (exp_pend) exp_code = `ECODE_INT;
        else if (rob_exc_i[0] != EXC_NONE) exp_code = class_code(rob_exc_i[0]);
        else exp_code = `ECODE_IPE;
        exp_op = (rob_valid_i[0] && !exp_exc) ? rob_csr_op_i[0] : CSR_NONE;
        case (rob_csr_num_i[0])
            `CSR_CRMD:   exp_old = m_crmd;
            `CSR_PRMD:   exp_old = m_prmd;
            `CSR_ECFG:   exp_old = m_ecfg;
            `CSR_ESTAT:  exp_old = m_estat;
            `CSR_ERA:    exp_old = m_era;
            `CSR_EENTRY: exp_old = m_eentry;
            `CSR_SAVE0:  exp_old = m_save0;
            default:     exp_old = '0;
        endcase
        exp_new = (exp_op == CSR_XCHG) ?
                  ((exp_old & ~rob_mask_i[0]) | (rob_wdata_i[0] & rob_mask_i[0])) : rob_wdata_i[0];
        exp_req[0] = rob_valid_i[0];
        exp_req[1] = rob_valid_i == 2'b11 && rob_single_i == 2'b00 && !exp_exc
                     && rob_exc_i[0] == EXC_NONE && rob_exc_i[1] == EXC_NONE
                     && rob_csr_op_i[0] == CSR_NONE && rob_csr_op_i[1] == CSR_NONE;
        exp_we[0] = rob_valid_i[0] && rob_wen_i[0] && !exp_exc;
        exp_we[1] = exp_req[1] && rob_wen_i[1];
        exp_data0 = (exp_op inside {CSR_RD, CSR_WR, CSR_XCHG}) ? exp_old : rob_wdata_i[0];
        exp_flush = exp_exc || exp_op == CSR_ERTN || exp_op == CSR_WR || exp_op == CSR_XCHG;
        if (exp_exc) exp_redirect = m_eentry;
        else if (exp_op == CSR_ERTN) exp_redirect = m_era;
        else if (exp_flush) exp_redirect = rob_pc_i[0] + 32'd4;
        else exp_redirect = '0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            m_crmd   <= 32'h8;
            m_prmd   <= '0;
            m_ecfg   <= '0;
            m_estat  <= '0;
            m_era    <= '0;
            m_eentry <= '0;
            m_save0  <= '0;
        end else begin
            m_estat[9:2] <= hw_int_i;
            if (exp_exc) begin
                m_era          <= rob_pc_i[0];
                m_prmd[2:0]    <= m_crmd[2:0];
                m_crmd[2:0]    <= 3'b000;
                m_estat[21:16] <= exp_code;
            end else if (exp_op == CSR_ERTN) begin
                m_crmd[2:0] <= m_prmd[2:0];
            end else if (exp_op == CSR_WR || exp_op == CSR_XCHG) begin
                case (rob_csr_num_i[0])
                    `CSR_CRMD:   m_crmd       <= exp_new;
                    `CSR_PRMD:   m_prmd       <= exp_new;
                    `CSR_ECFG:   m_ecfg       <= exp_new;
                    `CSR_ESTAT:  m_estat[1:0] <= exp_new[1:0];
                    `CSR_ERA:    m_era        <= exp_new;
                    `CSR_EENTRY: m_eentry     <= exp_new & 32'hffff_ffc0;
                    `CSR_SAVE0:  m_save0      <= exp_new;
                    default:     ;
                endcase
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && exp_exc) exc_seen <= exc_seen + 1;
    end

    // ------------------------------
    // outputs against the model
    a_req: assert property (@(negedge clk) disable iff (!rst_n) commit_req_o == exp_req)
        else value_error("commit_req_o", 32'(commit_req_o), 32'(exp_req));
    a_we: assert property (@(negedge clk) disable iff (!rst_n) arf_we_o == exp_we)
        else value_error("arf_we_o", 32'(arf_we_o), 32'(exp_we));
    a_areg0: assert property (@(negedge clk) disable iff (!rst_n)
        exp_we[0] |-> arf_areg_o[0] == rob_areg_i[0])
        else value_error("arf_areg_o[0]", 32'(arf_areg_o[0]), 32'(rob_areg_i[0]));
    a_data0: assert property (@(negedge clk) disable iff (!rst_n)
        exp_we[0] |-> arf_data_o[0] == exp_data0)
        else value_error("arf_data_o[0]", arf_data_o[0], exp_data0);
    a_areg1: assert property (@(negedge clk) disable iff (!rst_n)
        exp_we[1] |-> arf_areg_o[1] == rob_areg_i[1])
        else value_error("arf_areg_o[1]", 32'(arf_areg_o[1]), 32'(rob_areg_i[1]));
    a_data1: assert property (@(negedge clk) disable iff (!rst_n)
        exp_we[1] |-> arf_data_o[1] == rob_wdata_i[1])
        else value_error("arf_data_o[1]", arf_data_o[1], rob_wdata_i[1]);
    a_flush: assert property (@(negedge clk) disable iff (!rst_n) flush_o == exp_flush)
        else value_error("flush_o", 32'(flush_o), 32'(exp_flush));
    a_redir: assert property (@(negedge clk) disable iff (!rst_n) redirect_pc_o == exp_redirect)
        else value_error("redirect_pc_o", redirect_pc_o, exp_redirect);

    // ------------------------------
    // stimulus
    initial begin
        instr_t it;
        rst_n           <= 1'b0;
        rob_valid_i     <= '0;
        rob_pc_i        <= '0;
        rob_wen_i       <= '0;
        rob_areg_i      <= '0;
        rob_wdata_i     <= '0;
        rob_single_i    <= '0;
        rob_exc_i[0]    <= EXC_NONE;
        rob_exc_i[1]    <= EXC_NONE;
        rob_csr_op_i[0] <= CSR_NONE;
        rob_csr_op_i[1] <= CSR_NONE;
        rob_csr_num_i   <= '0;
        rob_mask_i      <= '0;
        hw_int_i        <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // plain pairs retire together with one slot 0 and one slot 1 not writing
        for (int i = 0; i < 8; i++) begin
            it = plain_instr();
            it.wen = (i != 4) && (i != 7);
            pending.push_back(it);
        end
        drain_queue();

        // single on slot 0, single on slot 1, fault on slot 1
        it = plain_instr();
        it.single = 1'b1;
        pending.push_back(it);
        pending.push_back(plain_instr());
        it = plain_instr();
        it.single = 1'b1;
        pending.push_back(it);
        pending.push_back(plain_instr());
        it = plain_instr();
        it.exc = EXC_ALE;
        pending.push_back(it);
        drain_queue();

        // syscall entry then estat and era
        pending.push_back(make_instr(CSR_WR, `CSR_EENTRY, rand_bits(32), '0));
        it = plain_instr();
        it.exc = EXC_SYS;
        pending.push_back(it);
        pending.push_back(make_instr(CSR_RD, `CSR_ESTAT, '0, '0));
        pending.push_back(make_instr(CSR_RD, `CSR_ERA, '0, '0));
        drain_queue();

        // write and exchange with read back
        pending.push_back(make_instr(CSR_WR, `CSR_SAVE0, rand_bits(32), '0));
        pending.push_back(make_instr(CSR_XCHG, `CSR_SAVE0, rand_bits(32), rand_bits(32)));
        // csr op on slot 1 keeps the plain one alone
        pending.push_back(plain_instr());
        pending.push_back(make_instr(CSR_RD, `CSR_SAVE0, '0, '0));
        // unknown number reads as zero
        pending.push_back(make_instr(CSR_WR, 14'h3f1, rand_bits(32), '0));
        pending.push_back(make_instr(CSR_RD, 14'h3f1, '0, '0));
        drain_queue();

        // hardware line 0 is estat bit 2
        pending.push_back(make_instr(CSR_WR, `CSR_ECFG, 32'h4, '0));
        pending.push_back(make_instr(CSR_WR, `CSR_CRMD, 32'h4, '0));
        drain_queue();
        @(posedge clk);
        hw_int_i <= 8'h01;
        pending.push_back(plain_instr());
        drain_queue();
        @(posedge clk);
        hw_int_i <= '0;
        pending.push_back(make_instr(CSR_ERTN, '0, '0, '0));
        pending.push_back(make_instr(CSR_RD, `CSR_CRMD, '0, '0));
        drain_queue();

        // return to plv 3 where a privileged read traps
        pending.push_back(make_instr(CSR_WR, `CSR_PRMD, 32'h3, '0));
        pending.push_back(make_instr(CSR_ERTN, '0, '0, '0));
        pending.push_back(make_instr(CSR_RD, `CSR_ESTAT, '0, '0));
        pending.push_back(make_instr(CSR_RD, `CSR_ESTAT, '0, '0));
        drain_queue();

        repeat (2) @(posedge clk);
        if (exc_seen != 4) begin
            stop_run($sformatf("expected 4 exceptions but %0d were taken", exc_seen));
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: commit_stage.f
+incdir+logic
logic/commit_pkg.sv
logic/commit_if.sv
logic/commit_issue.sv
logic/csr_unit.sv
logic/commit_writeback.sv
logic/commit_stage.sv
tb/tb_commit_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile tb_commit_stage with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f commit_stage.f --top-module tb_commit_stage -o tb_commit_stage \
    && ./obj_dir/tb_commit_stage | tee /dev/stderr | grep -F "ALL TESTS PASSED" > /dev/null \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
